// ==== local_irq_ctrl.sv ====
/* One word per source at 4*id: pending bit 0, enable bit 1, level 15:8.
   Sources are edge triggered; words beyond NumSources read as zero */
module local_irq_ctrl #(
  parameter int unsigned NumSources = 40
) (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  input  logic [NumSources-1:0]           intr_src_i,
  input  logic                            sel_valid_i,
  input  logic                            write_i,
  input  logic [11:0]                     offset_i,
  input  logic [31:0]                     wdata_i,
  output logic [31:0]                     rdata_o,
  output logic                            irq_valid_o,
  input  logic                            irq_ready_i,
  output logic [$clog2(NumSources)-1:0]   irq_id_o,
  output safety_irq_pkg::irq_level_t      irq_level_o
);

  localparam int unsigned IdW = $clog2(NumSources);

  logic [NumSources-1:0]      src_q, pending_q, enable_q, src_rise;
  safety_irq_pkg::irq_level_t level_q [NumSources];
  logic [9:0]                 reg_idx;
  logic                       reg_wr, irq_ack;
  logic                       best_valid;
  logic [IdW-1:0]             best_id;
  safety_irq_pkg::irq_level_t best_level;

  assign reg_idx  = offset_i[11:2];
  assign reg_wr   = sel_valid_i & write_i;
  assign src_rise = intr_src_i & ~src_q;
  assign irq_ack  = best_valid & irq_ready_i;

  // Ack clears, a new edge sets, a register write overrides both
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      src_q     <= '0;
      pending_q <= '0;
      enable_q  <= '0;
      for (int i = 0; i < NumSources; i++) begin
        level_q[i] <= '0;
      end
    end else begin
      src_q <= intr_src_i;
      for (int i = 0; i < NumSources; i++) begin
        if (irq_ack && best_id == IdW'(i)) begin
          pending_q[i] <= 1'b0;
        end
        if (src_rise[i]) begin
          pending_q[i] <= 1'b1;
        end
        if (reg_wr && reg_idx == 10'(i)) begin
          pending_q[i] <= wdata_i[0];
          enable_q[i]  <= wdata_i[1];
          level_q[i]   <= wdata_i[15:8];
        end
      end
    end
  end

  // Highest level wins, later ids win ties
  always_comb begin
    best_valid = 1'b0;
    best_id    = '0;
    best_level = '0;
    for (int i = 0; i < NumSources; i++) begin
      if (pending_q[i] && enable_q[i] && level_q[i] != '0 && level_q[i] >= best_level) begin
        best_valid = 1'b1;
        best_id    = IdW'(i);
        best_level = level_q[i];
      end
    end
  end

  always_comb begin
    rdata_o = '0;
    for (int i = 0; i < NumSources; i++) begin
      if (reg_idx == 10'(i)) begin
        rdata_o = {16'h0000, level_q[i], 6'b00_0000, enable_q[i], pending_q[i]};
      end
    end
  end

  assign irq_valid_o = best_valid;
  assign irq_id_o    = best_id;
  assign irq_level_o = best_level;

endmodule

// ==== obi_err_unit.sv ====
/* Assumes in-order OBI responses; rvalid with nothing outstanding is ignored.
   STATUS holds the count below bit 8, so NumStoredErrors must stay under 256 */
module obi_err_unit #(
  parameter int unsigned NumBusErrBits   = 2,
  parameter int unsigned NumOutstanding  = 2,
  parameter int unsigned NumStoredErrors = 8
) (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     obi_req_i,
  input  logic                     obi_gnt_i,
  input  logic                     obi_rvalid_i,
  input  logic [31:0]              obi_addr_i,
  input  logic [NumBusErrBits-1:0] obi_err_i,
  input  logic                     sel_valid_i,
  input  logic                     write_i,
  input  logic [11:0]              offset_i,
  output logic [31:0]              rdata_o,
  output logic                     err_irq_o
);

  localparam int unsigned OutPtrW = (NumOutstanding > 1) ? $clog2(NumOutstanding) : 1;
  localparam int unsigned OutCntW = $clog2(NumOutstanding + 1);
  localparam int unsigned ErrPtrW = (NumStoredErrors > 1) ? $clog2(NumStoredErrors) : 1;
  localparam int unsigned ErrCntW = $clog2(NumStoredErrors + 1);

  logic [31:0]              out_addr_q [NumOutstanding];
  logic [OutPtrW-1:0]       out_wr_ptr_q, out_rd_ptr_q;
  logic [OutCntW-1:0]       out_cnt_q;
  logic [31:0]              err_addr_q [NumStoredErrors];
  logic [NumBusErrBits-1:0] err_code_q [NumStoredErrors];
  logic [ErrPtrW-1:0]       err_wr_ptr_q, err_rd_ptr_q;
  logic [ErrCntW-1:0]       err_cnt_q, err_cnt_d;
  logic                     overflow_q, err_irq_q;
  logic                     out_push, out_pop, err_seen, err_push, err_pop, err_full, clr_ovf;

  assign out_push = obi_req_i & obi_gnt_i;
  assign out_pop  = obi_rvalid_i & (out_cnt_q != '0);
  assign err_seen = out_pop & (obi_err_i != '0);
  assign err_full = (err_cnt_q == ErrCntW'(NumStoredErrors));
  assign err_pop  = sel_valid_i & ~write_i & (err_cnt_q != '0) &
                    (offset_i[7:0] == safety_periph_pkg::ErrCodeOffset);
  // A pop in the same cycle frees the slot
  assign err_push = err_seen & (~err_full | err_pop);
  assign clr_ovf  = sel_valid_i & write_i & (offset_i[7:0] == safety_periph_pkg::ErrStatusOffset);
  assign err_cnt_d = err_cnt_q + ErrCntW'(err_push) - ErrCntW'(err_pop);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      out_wr_ptr_q <= '0;
      out_rd_ptr_q <= '0;
      out_cnt_q    <= '0;
      err_wr_ptr_q <= '0;
      err_rd_ptr_q <= '0;
      err_cnt_q    <= '0;
      overflow_q   <= 1'b0;
      err_irq_q    <= 1'b0;
    end else begin
      if (out_push) begin
        out_wr_ptr_q <= (out_wr_ptr_q == OutPtrW'(NumOutstanding - 1)) ? '0 : out_wr_ptr_q + 1'b1;
      end
      if (out_pop) begin
        out_rd_ptr_q <= (out_rd_ptr_q == OutPtrW'(NumOutstanding - 1)) ? '0 : out_rd_ptr_q + 1'b1;
      end
      out_cnt_q <= out_cnt_q + OutCntW'(out_push) - OutCntW'(out_pop);
      if (err_push) begin
        err_wr_ptr_q <= (err_wr_ptr_q == ErrPtrW'(NumStoredErrors - 1)) ? '0 : err_wr_ptr_q + 1'b1;
      end
      if (err_pop) begin
        err_rd_ptr_q <= (err_rd_ptr_q == ErrPtrW'(NumStoredErrors - 1)) ? '0 : err_rd_ptr_q + 1'b1;
      end
      err_cnt_q <= err_cnt_d;
      // Dropped error wins over a clear in the same cycle
      if (err_seen && !err_push) begin
        overflow_q <= 1'b1;
      end else if (clr_ovf) begin
        overflow_q <= 1'b0;
      end
      err_irq_q <= (err_cnt_d != '0);
    end
  end

  always_ff @(posedge clk_i) begin
    if (out_push) begin
      out_addr_q[out_wr_ptr_q] <= obi_addr_i;
    end
    if (err_push) begin
      err_addr_q[err_wr_ptr_q] <= out_addr_q[out_rd_ptr_q];
      err_code_q[err_wr_ptr_q] <= obi_err_i;
    end
  end

  always_comb begin
    rdata_o = '0;
    case (offset_i[7:0])
      safety_periph_pkg::ErrStatusOffset: begin
        rdata_o[ErrCntW-1:0] = err_cnt_q;
        rdata_o[8]           = overflow_q;
      end
      safety_periph_pkg::ErrAddrOffset: begin
        if (err_cnt_q != '0) rdata_o = err_addr_q[err_rd_ptr_q];
      end
      safety_periph_pkg::ErrCodeOffset: begin
        if (err_cnt_q != '0) rdata_o[NumBusErrBits-1:0] = err_code_q[err_rd_ptr_q];
      end
      default: ;
    endcase
  end

  assign err_irq_o = err_irq_q;

endmodule

// ==== regbus_demux.sv ====
/* Single-cycle register bus decode; PeriphBaseAddr must be 4 KiB aligned.
   Offsets forwarded are the low 12 address bits, not window relative */
module regbus_demux #(
  parameter logic [31:0] PeriphBaseAddr = 32'h0020_0000
) (
  input  logic        reg_valid_i,
  input  logic        reg_write_i,
  input  logic [31:0] reg_addr_i,
  input  logic [31:0] reg_wdata_i,
  output logic        reg_ready_o,
  output logic [31:0] reg_rdata_o,
  output logic        reg_error_o,

  output logic [safety_periph_pkg::NumCoreLocalPeriphs-1:0]       sel_valid_o,
  output logic                                                    write_o,
  output logic [11:0]                                             offset_o,
  output logic [31:0]                                             wdata_o,
  input  logic [safety_periph_pkg::NumCoreLocalPeriphs-1:0][31:0] rdata_i
);

  logic [31:0] win_base [safety_periph_pkg::NumCoreLocalPeriphs];
  logic [31:0] win_size [safety_periph_pkg::NumCoreLocalPeriphs];
  safety_periph_pkg::regbus_idx_t sel_idx;
  logic hit;

  always_comb begin
    win_base[safety_periph_pkg::RegbusOutIrqCtrl]   = PeriphBaseAddr + safety_periph_pkg::IrqCtrlOffset;
    win_size[safety_periph_pkg::RegbusOutIrqCtrl]   = safety_periph_pkg::IrqCtrlRange;
    win_base[safety_periph_pkg::RegbusOutInstrErr]  = PeriphBaseAddr + safety_periph_pkg::InstrErrOffset;
    win_size[safety_periph_pkg::RegbusOutInstrErr]  = safety_periph_pkg::ErrUnitRange;
    win_base[safety_periph_pkg::RegbusOutDataErr]   = PeriphBaseAddr + safety_periph_pkg::DataErrOffset;
    win_size[safety_periph_pkg::RegbusOutDataErr]   = safety_periph_pkg::ErrUnitRange;
    win_base[safety_periph_pkg::RegbusOutShadowErr] = PeriphBaseAddr + safety_periph_pkg::ShadowErrOffset;
    win_size[safety_periph_pkg::RegbusOutShadowErr] = safety_periph_pkg::ErrUnitRange;
  end

  // Unsigned difference covers both window bounds
  always_comb begin
    hit     = 1'b0;
    sel_idx = '0;
    for (int i = 0; i < safety_periph_pkg::NumCoreLocalPeriphs; i++) begin
      if ((reg_addr_i - win_base[i]) < win_size[i]) begin
        hit     = 1'b1;
        sel_idx = safety_periph_pkg::regbus_idx_t'(i);
      end
    end
  end

  always_comb begin
    sel_valid_o = '0;
    if (reg_valid_i && hit) begin
      sel_valid_o[sel_idx] = 1'b1;
    end
  end

  assign write_o  = reg_write_i;
  assign offset_o = reg_addr_i[11:0];
  assign wdata_o  = reg_wdata_i;

  // No back-pressure, every access ends in its own cycle
  assign reg_ready_o = reg_valid_i;
  assign reg_error_o = reg_valid_i & ~hit;
  assign reg_rdata_o = hit ? rdata_i[sel_idx] : safety_periph_pkg::RegErrVal;

endmodule

// ==== safety_irq_pkg.sv ====
/* Interrupt line layout of the core-local controller.
   Lines below IrqExtBase are local; external lines follow from IrqExtBase up */
package safety_irq_pkg;

  // Machine timer alias of timer line 0
  localparam int IrqMtip = 7;

  localparam int IrqTimerBase = 16;
  localparam int NumTimerIrqs = 2;

  // Bus error units
  localparam int IrqInstrErr  = 18;
  localparam int IrqDataErr   = 19;
  localparam int IrqShadowErr = 20;

  localparam int IrqExtBase   = 32;
  localparam int NumLocalIrqs = 32;

  typedef logic [7:0] irq_level_t;

endpackage

// ==== safety_periph_asserts.sv ====
/* Concurrent checks bound into safety_periph_top.
   Port index 0 is instr, 1 data, 2 shadow */
module safety_periph_asserts #(
  parameter int unsigned NumOutstanding = 2
) (
  input logic                                             clk_i,
  input logic                                             rst_n_i,
  input logic                                             reg_valid_i,
  input logic                                             reg_ready_o,
  input logic                                             irq_valid_o,
  input logic [7:0]                                       irq_level_o,
  input logic [2:0]                                       req_i,
  input logic [2:0]                                       gnt_i,
  input logic [2:0]                                       rvalid_i,
  input logic [2:0][$clog2(NumOutstanding + 1)-1:0]       out_cnt_i
);
  timeunit 1ns;
  timeprecision 100ps;

  int unsigned fail_count = 0;

  assert property (@(posedge clk_i) disable iff (!rst_n_i) reg_ready_o == reg_valid_i)
    else begin
      $error("reg_ready_o differs from reg_valid_i");
      fail_count++;
    end

  assert property (@(posedge clk_i) disable iff (!rst_n_i) irq_valid_o |-> irq_level_o != '0)
    else begin
      $error("interrupt offered with level zero");
      fail_count++;
    end

  assert property (@(posedge clk_i) $rose(rst_n_i) |-> !irq_valid_o)
    else begin
      $error("irq_valid_o high right after reset release");
      fail_count++;
    end

  // A grant at a full FIFO is only safe when a response pops in the same cycle
  for (genvar p = 0; p < 3; p++) begin : g_port
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (req_i[p] && gnt_i[p]) |-> (out_cnt_i[p] < NumOutstanding || rvalid_i[p]))
      else begin
        $error("outstanding FIFO of port %0d would overflow", p);
        fail_count++;
      end
  end

endmodule

bind safety_periph_top safety_periph_asserts #(
  .NumOutstanding ( NumOutstanding )
) i_asserts (
  .clk_i,
  .rst_n_i,
  .reg_valid_i,
  .reg_ready_o,
  .irq_valid_o,
  .irq_level_o,
  .req_i     ( {shadow_req_i, data_req_i, instr_req_i} ),
  .gnt_i     ( {shadow_gnt_i, data_gnt_i, instr_gnt_i} ),
  .rvalid_i  ( {shadow_rvalid_i, data_rvalid_i, instr_rvalid_i} ),
  .out_cnt_i ( {i_shadow_err.out_cnt_q, i_data_err.out_cnt_q, i_instr_err.out_cnt_q} )
);

// ==== safety_periph_pkg.sv ====
/* Register map of the core-local peripherals, relative to the peripheral base.
   Error-unit register offsets are decoded from the low 8 address bits */
package safety_periph_pkg;

  // Demux output indices
  localparam int RegbusOutIrqCtrl   = 0;
  localparam int RegbusOutInstrErr  = 1;
  localparam int RegbusOutDataErr   = 2;
  localparam int RegbusOutShadowErr = 3;
  localparam int NumCoreLocalPeriphs = 4;

  typedef logic [$clog2(NumCoreLocalPeriphs)-1:0] regbus_idx_t;

  localparam logic [31:0] IrqCtrlOffset   = 32'h0000_0000;
  localparam logic [31:0] IrqCtrlRange    = 32'h0000_1000;
  localparam logic [31:0] InstrErrOffset  = 32'h0000_1000;
  localparam logic [31:0] DataErrOffset   = 32'h0000_1100;
  localparam logic [31:0] ShadowErrOffset = 32'h0000_1200;
  localparam logic [31:0] ErrUnitRange    = 32'h0000_0100;

  // Error unit registers
  localparam logic [7:0] ErrStatusOffset = 8'h00;
  localparam logic [7:0] ErrAddrOffset   = 8'h04;
  localparam logic [7:0] ErrCodeOffset   = 8'h08;

  // Returned on an unmapped access
  localparam logic [31:0] RegErrVal = 32'hBADC_AB1E;

endpackage

// ==== safety_periph_top.f ====
safety_periph_pkg.sv
safety_irq_pkg.sv
regbus_demux.sv
obi_err_unit.sv
local_irq_ctrl.sv
safety_periph_top.sv
safety_periph_asserts.sv
tb_safety_periph_top.sv

// ==== safety_periph_top.sv ====
/* Core-local peripherals of the safety core: register demux, three bus error
   units and the interrupt controller. Line 21 is reserved and tied low */
module safety_periph_top #(
  parameter logic [31:0] PeriphBaseAddr  = 32'h0020_0000,
  parameter int unsigned NumExtIrqs      = 8,
  parameter int unsigned NumBusErrBits   = 2,
  parameter int unsigned NumOutstanding  = 2,
  parameter int unsigned NumStoredErrors = 8
) (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        reg_valid_i,
  input  logic        reg_write_i,
  input  logic [31:0] reg_addr_i,
  input  logic [31:0] reg_wdata_i,
  output logic        reg_ready_o,
  output logic [31:0] reg_rdata_o,
  output logic        reg_error_o,

  input  logic                     instr_req_i,
  input  logic                     instr_gnt_i,
  input  logic                     instr_rvalid_i,
  input  logic [31:0]              instr_addr_i,
  input  logic [NumBusErrBits-1:0] instr_err_i,
  input  logic                     data_req_i,
  input  logic                     data_gnt_i,
  input  logic                     data_rvalid_i,
  input  logic [31:0]              data_addr_i,
  input  logic [NumBusErrBits-1:0] data_err_i,
  input  logic                     shadow_req_i,
  input  logic                     shadow_gnt_i,
  input  logic                     shadow_rvalid_i,
  input  logic [31:0]              shadow_addr_i,
  input  logic [NumBusErrBits-1:0] shadow_err_i,

  input  logic [NumExtIrqs-1:0]                   ext_irqs_i,
  input  logic [safety_irq_pkg::NumTimerIrqs-1:0] timer_irqs_i,
  input  logic                                    irq_ready_i,
  output logic                                    irq_valid_o,
  output logic [$clog2(NumExtIrqs + safety_irq_pkg::NumLocalIrqs)-1:0] irq_id_o,
  output safety_irq_pkg::irq_level_t              irq_level_o
);

  localparam int unsigned NumSources = NumExtIrqs + safety_irq_pkg::NumLocalIrqs;

  logic [safety_periph_pkg::NumCoreLocalPeriphs-1:0]       periph_sel;
  logic [safety_periph_pkg::NumCoreLocalPeriphs-1:0][31:0] periph_rdata;
  logic                                                    periph_write;
  logic [11:0]                                             periph_offset;
  logic [31:0]                                             periph_wdata;
  logic [2:0]                                              bus_err_irq;
  logic [NumSources-1:0]                                   irq_src;

  regbus_demux #(
    .PeriphBaseAddr ( PeriphBaseAddr )
  ) i_regbus_demux (
    .reg_valid_i,
    .reg_write_i,
    .reg_addr_i,
    .reg_wdata_i,
    .reg_ready_o,
    .reg_rdata_o,
    .reg_error_o,
    .sel_valid_o ( periph_sel    ),
    .write_o     ( periph_write  ),
    .offset_o    ( periph_offset ),
    .wdata_o     ( periph_wdata  ),
    .rdata_i     ( periph_rdata  )
  );

  obi_err_unit #(
    .NumBusErrBits   ( NumBusErrBits   ),
    .NumOutstanding  ( NumOutstanding  ),
    .NumStoredErrors ( NumStoredErrors )
  ) i_instr_err (
    .clk_i,
    .rst_n_i,
    .obi_req_i    ( instr_req_i    ),
    .obi_gnt_i    ( instr_gnt_i    ),
    .obi_rvalid_i ( instr_rvalid_i ),
    .obi_addr_i   ( instr_addr_i   ),
    .obi_err_i    ( instr_err_i    ),
    .sel_valid_i  ( periph_sel[safety_periph_pkg::RegbusOutInstrErr]   ),
    .write_i      ( periph_write   ),
    .offset_i     ( periph_offset  ),
    .rdata_o      ( periph_rdata[safety_periph_pkg::RegbusOutInstrErr] ),
    .err_irq_o    ( bus_err_irq[0] )
  );

  obi_err_unit #(
    .NumBusErrBits   ( NumBusErrBits   ),
    .NumOutstanding  ( NumOutstanding  ),
    .NumStoredErrors ( NumStoredErrors )
  ) i_data_err (
    .clk_i,
    .rst_n_i,
    .obi_req_i    ( data_req_i     ),
    .obi_gnt_i    ( data_gnt_i     ),
    .obi_rvalid_i ( data_rvalid_i  ),
    .obi_addr_i   ( data_addr_i    ),
    .obi_err_i    ( data_err_i     ),
    .sel_valid_i  ( periph_sel[safety_periph_pkg::RegbusOutDataErr]   ),
    .write_i      ( periph_write   ),
    .offset_i     ( periph_offset  ),
    .rdata_o      ( periph_rdata[safety_periph_pkg::RegbusOutDataErr] ),
    .err_irq_o    ( bus_err_irq[1] )
  );

  obi_err_unit #(
    .NumBusErrBits   ( NumBusErrBits   ),
    .NumOutstanding  ( NumOutstanding  ),
    .NumStoredErrors ( NumStoredErrors )
  ) i_shadow_err (
    .clk_i,
    .rst_n_i,
    .obi_req_i    ( shadow_req_i    ),
    .obi_gnt_i    ( shadow_gnt_i    ),
    .obi_rvalid_i ( shadow_rvalid_i ),
    .obi_addr_i   ( shadow_addr_i   ),
    .obi_err_i    ( shadow_err_i    ),
    .sel_valid_i  ( periph_sel[safety_periph_pkg::RegbusOutShadowErr]   ),
    .write_i      ( periph_write    ),
    .offset_i     ( periph_offset   ),
    .rdata_o      ( periph_rdata[safety_periph_pkg::RegbusOutShadowErr] ),
    .err_irq_o    ( bus_err_irq[2]  )
  );

  // Source vector, unlisted local lines stay zero
  always_comb begin
    irq_src = '0;
    irq_src[safety_irq_pkg::IrqMtip] = timer_irqs_i[0];
    irq_src[safety_irq_pkg::IrqTimerBase +: safety_irq_pkg::NumTimerIrqs] = timer_irqs_i;
    irq_src[safety_irq_pkg::IrqInstrErr]  = bus_err_irq[0];
    irq_src[safety_irq_pkg::IrqDataErr]   = bus_err_irq[1];
    irq_src[safety_irq_pkg::IrqShadowErr] = bus_err_irq[2];
    irq_src[safety_irq_pkg::IrqExtBase +: NumExtIrqs] = ext_irqs_i;
  end

  local_irq_ctrl #(
    .NumSources ( NumSources )
  ) i_local_irq_ctrl (
    .clk_i,
    .rst_n_i,
    .intr_src_i  ( irq_src       ),
    .sel_valid_i ( periph_sel[safety_periph_pkg::RegbusOutIrqCtrl]   ),
    .write_i     ( periph_write  ),
    .offset_i    ( periph_offset ),
    .wdata_i     ( periph_wdata  ),
    .rdata_o     ( periph_rdata[safety_periph_pkg::RegbusOutIrqCtrl] ),
    .irq_valid_o,
    .irq_ready_i,
    .irq_id_o,
    .irq_level_o
  );

endmodule

// ==== tb_safety_periph_top.sv ====
/* Table-driven testbench for safety_periph_top at its default parameters.
   Random addresses and error codes come from one fixed seed */
module tb_safety_periph_top;
  timeunit 1ns;
  timeprecision 100ps;

  localparam logic [31:0] Base = 32'h0020_0000;
  localparam int KWr = 0, KRd = 1, KRdUnmapped = 2, KReq = 3, KRsp = 4;
  localparam int KPulse = 5, KAck = 6, KIdle = 7, KRst = 8;

  logic        clk = 1'b0;
  logic        rst_n, reg_valid, reg_write, reg_ready, reg_error;
  logic [31:0] reg_addr, reg_wdata, reg_rdata;
  logic [2:0]  obi_req, obi_gnt, obi_rvalid;
  logic [31:0] obi_addr [3];
  logic [1:0]  obi_err [3];
  logic [7:0]  ext_irqs, irq_level;
  logic [1:0]  timer_irqs;
  logic        irq_ready, irq_valid;
  logic [5:0]  irq_id;
  logic        table_ready = 1'b0;
  int          kind_q[$], test_q[$];
  logic [31:0] addr_q[$], data_q[$], exp_q[$];
  int          errors = 0, checks = 0, tests_passed = 0, tests_failed = 0;
  string       test_name [6] = '{"unmapped", "readback", "priority", "error capture",
                                 "overflow", "reset state"};
  logic [31:0] rdata, wait_cnt;
  logic        err;
  int          port;

  safety_periph_top dut (
    .clk_i (clk), .rst_n_i (rst_n),
    .reg_valid_i (reg_valid), .reg_write_i (reg_write), .reg_addr_i (reg_addr),
    .reg_wdata_i (reg_wdata), .reg_ready_o (reg_ready), .reg_rdata_o (reg_rdata),
    .reg_error_o (reg_error),
    .instr_req_i (obi_req[0]), .instr_gnt_i (obi_gnt[0]), .instr_rvalid_i (obi_rvalid[0]),
    .instr_addr_i (obi_addr[0]), .instr_err_i (obi_err[0]),
    .data_req_i (obi_req[1]), .data_gnt_i (obi_gnt[1]), .data_rvalid_i (obi_rvalid[1]),
    .data_addr_i (obi_addr[1]), .data_err_i (obi_err[1]),
    .shadow_req_i (obi_req[2]), .shadow_gnt_i (obi_gnt[2]), .shadow_rvalid_i (obi_rvalid[2]),
    .shadow_addr_i (obi_addr[2]), .shadow_err_i (obi_err[2]),
    .ext_irqs_i (ext_irqs), .timer_irqs_i (timer_irqs), .irq_ready_i (irq_ready),
    .irq_valid_o (irq_valid), .irq_id_o (irq_id), .irq_level_o (irq_level)
  );

  always #50 clk = ~clk;

  function automatic void add_entry(int test, int kind, logic [31:0] addr, logic [31:0] data,
                                    logic [31:0] exp);
    test_q.push_back(test);
    kind_q.push_back(kind);
    addr_q.push_back(addr);
    data_q.push_back(data);
    exp_q.push_back(exp);
  endfunction

  function automatic logic [31:0] irq_word(int id);
    return Base + safety_periph_pkg::IrqCtrlOffset + 32'(4 * id);
  endfunction

  function automatic logic [31:0] err_reg(logic [31:0] unit, logic [7:0] reg_off);
    return Base + unit + 32'(reg_off);
  endfunction

  // Enable in bit 1, level in 15:8, pending left clear
  function automatic logic [31:0] irq_cfg(logic [7:0] level);
    return (32'(level) << 8) | 32'h2;
  endfunction

  function automatic logic [31:0] status_word(int count, logic ovf);
    return 32'(count) | (ovf ? 32'h100 : 32'h0);
  endfunction

  function automatic void check_value(logic [31:0] got, logic [31:0] exp, string what);
    checks++;
    if (got !== exp) begin
      $display("ERROR at %0t: %s gave %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endfunction

  task build_table();
    logic [31:0] cap_addr, clean_addr;
    logic [31:0] ovf_addr [9];
    logic [1:0]  cap_code;
    logic [1:0]  ovf_code [9];
    int          ext;
    ext        = safety_irq_pkg::IrqExtBase;
    cap_addr   = $urandom & 32'hFFFF_FFFC;
    clean_addr = $urandom & 32'hFFFF_FFFC;
    cap_code   = 2'(($urandom % 3) + 1);
    for (int k = 0; k < 9; k++) begin
      ovf_addr[k] = $urandom & 32'hFFFF_FFFC;
      ovf_code[k] = 2'(($urandom % 3) + 1);
    end
    add_entry(0, KRdUnmapped, Base + 32'h2000, 0, safety_periph_pkg::RegErrVal);
    add_entry(0, KRd, err_reg(safety_periph_pkg::InstrErrOffset, 8'h00), 0, 0);
    add_entry(1, KWr, irq_word(ext + 1), irq_cfg(5), 0);
    add_entry(1, KWr, irq_word(ext + 3), irq_cfg(9), 0);
    add_entry(1, KRd, irq_word(ext + 1), 0, irq_cfg(5));
    add_entry(1, KRd, irq_word(ext + 3), 0, irq_cfg(9));
    // Acks carry the expected level in the data column
    add_entry(2, KPulse, 0, 32'b0000_1010, 0);
    add_entry(2, KAck, 0, 9, ext + 3);
    add_entry(2, KAck, 0, 5, ext + 1);
    add_entry(2, KWr, irq_word(ext + 5), irq_cfg(4), 0);
    add_entry(2, KWr, irq_word(ext + 6), irq_cfg(4), 0);
    add_entry(2, KPulse, 0, 32'b0110_0000, 0);
    add_entry(2, KAck, 0, 4, ext + 6);
    add_entry(2, KAck, 0, 4, ext + 5);
    add_entry(2, KIdle, 0, 0, 0);
    add_entry(3, KWr, irq_word(safety_irq_pkg::IrqDataErr), irq_cfg(3), 0);
    add_entry(3, KReq, cap_addr, 1, 0);
    add_entry(3, KRsp, 1, cap_code, 0);
    add_entry(3, KRd, err_reg(safety_periph_pkg::DataErrOffset, 8'h00), 0, status_word(1, 0));
    add_entry(3, KRd, err_reg(safety_periph_pkg::DataErrOffset, 8'h04), 0, cap_addr);
    add_entry(3, KReq, clean_addr, 1, 0);
    add_entry(3, KRsp, 1, 0, 0);
    add_entry(3, KRd, err_reg(safety_periph_pkg::DataErrOffset, 8'h00), 0, status_word(1, 0));
    add_entry(3, KAck, 0, 3, safety_irq_pkg::IrqDataErr);
    add_entry(3, KRd, err_reg(safety_periph_pkg::DataErrOffset, 8'h08), 0, 32'(cap_code));
    add_entry(3, KRd, err_reg(safety_periph_pkg::DataErrOffset, 8'h00), 0, status_word(0, 0));
    // Two requests in flight, the ninth error finds the queue full
    add_entry(4, KReq, ovf_addr[0], 0, 0);
    for (int k = 1; k < 9; k++) begin
      add_entry(4, KReq, ovf_addr[k], 0, 0);
      add_entry(4, KRsp, 0, 32'(ovf_code[k - 1]), 0);
    end
    add_entry(4, KRsp, 0, 32'(ovf_code[8]), 0);
    add_entry(4, KRd, err_reg(safety_periph_pkg::InstrErrOffset, 8'h00), 0, status_word(8, 1));
    for (int k = 0; k < 8; k++) begin
      add_entry(4, KRd, err_reg(safety_periph_pkg::InstrErrOffset, 8'h04), 0, ovf_addr[k]);
      add_entry(4, KRd, err_reg(safety_periph_pkg::InstrErrOffset, 8'h08), 0, 32'(ovf_code[k]));
    end
    add_entry(4, KRd, err_reg(safety_periph_pkg::InstrErrOffset, 8'h00), 0, status_word(0, 1));
    add_entry(4, KWr, err_reg(safety_periph_pkg::InstrErrOffset, 8'h00), 0, 0);
    add_entry(4, KRd, err_reg(safety_periph_pkg::InstrErrOffset, 8'h00), 0, status_word(0, 0));
    // Stored shadow error and an offered interrupt for the reset to clear
    add_entry(5, KReq, 32'h0000_0040, 2, 0);
    add_entry(5, KRsp, 2, 1, 0);
    add_entry(5, KPulse, 0, 32'b0000_1000, 0);
    add_entry(5, KRst, 0, 0, 0);
    add_entry(5, KIdle, 0, 0, 0);
    add_entry(5, KRd, err_reg(safety_periph_pkg::InstrErrOffset, 8'h00), 0, 0);
    add_entry(5, KRd, err_reg(safety_periph_pkg::DataErrOffset, 8'h00), 0, 0);
    add_entry(5, KRd, err_reg(safety_periph_pkg::ShadowErrOffset, 8'h00), 0, 0);
    add_entry(5, KRd, irq_word(ext + 3), 0, 0);
  endtask

  task apply_entry(input int i);
    case (kind_q[i])
      KWr, KRd, KRdUnmapped: begin
        @(posedge clk);
        reg_valid <= 1'b1;
        reg_write <= (kind_q[i] == KWr);
        reg_addr  <= addr_q[i];
        reg_wdata <= data_q[i];
        @(negedge clk);
        rdata = reg_rdata;
        err   = reg_error;
        @(posedge clk);
        reg_valid <= 1'b0;
        reg_write <= 1'b0;
        if (kind_q[i] != KWr) begin
          check_value(rdata, exp_q[i], $sformatf("read at %h", addr_q[i]));
          check_value(32'(err), 32'(kind_q[i] == KRdUnmapped), "reg_error_o");
        end
      end
      KReq: begin
        port = data_q[i];
        @(posedge clk);
        obi_req[port]  <= 1'b1;
        obi_gnt[port]  <= 1'b1;
        obi_addr[port] <= addr_q[i];
        @(posedge clk);
        obi_req[port] <= 1'b0;
        obi_gnt[port] <= 1'b0;
      end
      KRsp: begin
        port = addr_q[i];
        @(posedge clk);
        obi_rvalid[port] <= 1'b1;
        obi_err[port]    <= data_q[i][1:0];
        @(posedge clk);
        obi_rvalid[port] <= 1'b0;
        obi_err[port]    <= '0;
      end
      KPulse: begin
        @(posedge clk);
        ext_irqs <= data_q[i][7:0];
        @(posedge clk);
        ext_irqs <= '0;
      end
      KAck: begin
        wait_cnt = 0;
        @(negedge clk);
        while (!irq_valid && wait_cnt < 10) begin
          @(negedge clk);
          wait_cnt++;
        end
        if (!irq_valid) begin
          $display("no interrupt offered within 10 cycles at %0t, expected id %0d",
                   $time, exp_q[i]);
          errors++;
        end else begin
          check_value(32'(irq_id), exp_q[i], "irq_id_o");
          check_value(32'(irq_level), data_q[i], "irq_level_o");
          @(posedge clk);
          irq_ready <= 1'b1;
          @(posedge clk);
          irq_ready <= 1'b0;
        end
      end
      KIdle: begin
        @(negedge clk);
        check_value(32'(irq_valid), 0, "irq_valid_o");
      end
      default: begin
        @(posedge clk);
        rst_n <= 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
      end
    endcase
  endtask

  initial begin
    wait (table_ready);
    #(kind_q.size() * 20 * 100);
    $display("run timed out before all %0d table entries were applied", kind_q.size());
    $display("FAIL: see errors above");
    $finish;
  end

  initial begin
    int prev_errors;
    void'($urandom(32'h86ea));
    rst_n      <= 1'b0;
    reg_valid  <= 1'b0;
    reg_write  <= 1'b0;
    reg_addr   <= '0;
    reg_wdata  <= '0;
    obi_req    <= '0;
    obi_gnt    <= '0;
    obi_rvalid <= '0;
    ext_irqs   <= '0;
    timer_irqs <= '0;
    irq_ready  <= 1'b0;
    for (int p = 0; p < 3; p++) begin
      obi_addr[p] <= '0;
      obi_err[p]  <= '0;
    end
    build_table();
    table_ready = 1'b1;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    prev_errors = 0;
    for (int i = 0; i < kind_q.size(); i++) begin
      apply_entry(i);
      if (i == kind_q.size() - 1 || test_q[i + 1] != test_q[i]) begin
        $display("test %-14s %s", test_name[test_q[i]],
                 (errors == prev_errors) ? "passed" : "failed");
        if (errors == prev_errors) begin
          tests_passed++;
        end else begin
          tests_failed++;
        end
        prev_errors = errors;
      end
    end
    errors += dut.i_asserts.fail_count;
    $display("tests: %0d passed, %0d failed; checks: %0d; errors: %0d",
             tests_passed, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule
